//--- Bender.yml
package:
  name: fib_sequencer

sources:
  - files:
      - logic/fibPkg.sv
      - logic/regCtrlIf.sv
      - logic/termCountIf.sv
      - logic/seqController.sv
      - logic/stepCounter.sv
      - logic/fibDatapath.sv
      - logic/fibSequencer.sv
  - target: test
    files:
      - test/fibSequencerTb.sv

//--- logic/fibDatapath.sv
`timescale 1ns/100ps

module fibDatapath import fibPkg::*; (
	input logic clk,
	input logic rstN,
	regCtrlIf.dp regs,
	output data_t termData
);

	data_t regFile [numRegs];

	// read ports
	data_t rdA;
	data_t rdB;

	// alu
	data_t operandB;
	data_t aluResult;
	logic [dataWidth:0] sum;

	//////////////////////////////////////////////////
	// read ports and operand select
	//////////////////////////////////////////////////

	assign rdA = regFile[regs.readRegA];
	assign rdB = regFile[regs.readRegB];

	// immediate replaces port b
	assign operandB = regs.selectImm ? regs.imm : rdB;

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////

	// one extra bit catches the carry out
	assign sum = {1'b0, rdA} + {1'b0, operandB};

	always_comb begin
		case (regs.op)
			opAdd: begin
				aluResult = sum[dataWidth-1:0];
			end
			opImm: begin
				aluResult = operandB;
			end
			default: begin
				aluResult = operandB;
			end
		endcase
	end

	// only an add can overflow
	assign regs.carry = (regs.op == opAdd) && sum[dataWidth];

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regFile[i] <= '0;
			end
		end else if (regs.writeEn) begin
			regFile[regs.loadReg] <= aluResult;
		end
	end

	// term output shares port a
	assign termData = rdA;

endmodule

//--- logic/fibPkg.sv
package fibPkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	// one register holds one term
	localparam int dataWidth = 16;
	localparam int numRegs = 16;
	localparam int regAddrWidth = $clog2(numRegs);

	// requested number of terms
	localparam int countWidth = 8;

	typedef logic [dataWidth-1:0] data_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [countWidth-1:0] count_t;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	// add gives a carry, imm just passes operand b through
	typedef enum logic {
		opAdd,
		opImm
	} aluOp_t;

	// controller states
	// stEmit holds a term on the output until it is taken
	typedef enum logic [1:0] {
		stIdle,
		stLoadSecond,
		stEmit,
		stStep
	} seqState_t;

endpackage

//--- logic/fibSequencer.sv
`timescale 1ns/100ps

module fibSequencer import fibPkg::*; (
	input logic clk,
	input logic rstN,

	// request stream
	input logic reqValid,
	output logic reqReady,
	input data_t reqSeed0,
	input data_t reqSeed1,
	input count_t reqCount,

	// term stream
	output logic termValid,
	input logic termReady,
	output data_t termData,
	output logic termLast,
	output logic termOverflow
);

	//////////////////////////////////////////////////
	// internal buses
	//////////////////////////////////////////////////

	// register file and alu control
	regCtrlIf regBus ();

	// pointers and remaining count
	termCountIf cntBus ();

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	seqController ctrl (
		.clk (clk),
		.rstN (rstN),
		.reqValid (reqValid),
		.reqReady (reqReady),
		.reqSeed0 (reqSeed0),
		.reqSeed1 (reqSeed1),
		.reqCount (reqCount),
		.termValid (termValid),
		.termReady (termReady),
		.termLast (termLast),
		.termOverflow (termOverflow),
		.regs (regBus.ctrl),
		.cnt (cntBus.ctrl)
	);

	stepCounter counter (
		.clk (clk),
		.rstN (rstN),
		.cnt (cntBus.cnt)
	);

	// termData is read port a of the register file
	fibDatapath datapath (
		.clk (clk),
		.rstN (rstN),
		.regs (regBus.dp),
		.termData (termData)
	);

endmodule

//--- logic/regCtrlIf.sv
`timescale 1ns/100ps

interface regCtrlIf import fibPkg::*; ();

	// write port
	logic writeEn;
	regAddr_t loadReg;

	// read ports
	regAddr_t readRegA;
	regAddr_t readRegB;

	// operand b select and alu function
	logic selectImm;
	data_t imm;
	aluOp_t op;

	// carry out of the current add
	logic carry;

	modport ctrl (
		output writeEn, loadReg, readRegA, readRegB, selectImm, imm, op,
		input carry
	);

	modport dp (
		input writeEn, loadReg, readRegA, readRegB, selectImm, imm, op,
		output carry
	);

endinterface

//--- logic/seqController.sv
`timescale 1ns/100ps

module seqController import fibPkg::*; (
	input logic clk,
	input logic rstN,

	// request stream
	input logic reqValid,
	output logic reqReady,
	input data_t reqSeed0,
	input data_t reqSeed1,
	input count_t reqCount,

	// term stream, data comes from the datapath
	output logic termValid,
	input logic termReady,
	output logic termLast,
	output logic termOverflow,

	regCtrlIf.ctrl regs,
	termCountIf.ctrl cnt
);

	seqState_t state;
	seqState_t nextState;

	// second seed waits here until stLoadSecond
	data_t seed1Hold;

	// carry seen on the last add, ends the sequence at the next term
	logic ovfPending;

	// the term on the output is the first of this request
	logic firstTerm;

	logic accept;
	logic termTaken;
	logic writeEn;

	//////////////////////////////////////////////////
	// handshakes
	//////////////////////////////////////////////////

	assign reqReady = (state == stIdle);
	assign accept = reqValid && reqReady;

	assign termValid = (state == stEmit);
	assign termTaken = termValid && termReady;

	// an overflowed sum is always the final term
	assign termLast = termValid && (cnt.lastTerm || ovfPending);
	assign termOverflow = termValid && ovfPending;

	//////////////////////////////////////////////////
	// step counter control
	//////////////////////////////////////////////////

	assign cnt.load = accept;
	assign cnt.count = reqCount;
	assign cnt.writeStep = writeEn;
	assign cnt.emitStep = termTaken;

	assign regs.writeEn = writeEn;

	//////////////////////////////////////////////////
	// register file control and next state
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		writeEn = 1'b0;
		regs.loadReg = cnt.wrPtr;
		regs.readRegA = cnt.emitPtr;
		regs.readRegB = cnt.prevPtrB;
		regs.selectImm = 1'b0;
		regs.imm = '0;
		regs.op = opAdd;

		case (state)
			stIdle: begin
				// seed0 as immediate, the sequence always restarts at r0
				regs.loadReg = '0;
				regs.selectImm = 1'b1;
				regs.imm = reqSeed0;
				regs.op = opImm;
				if (accept) begin
					writeEn = 1'b1;
					// a zero count is taken and dropped
					if (reqCount != '0) begin
						nextState = stLoadSecond;
					end
				end
			end

			stLoadSecond: begin
				// seed1 goes to the register after seed0
				writeEn = 1'b1;
				regs.selectImm = 1'b1;
				regs.imm = seed1Hold;
				regs.op = opImm;
				nextState = stEmit;
			end

			stEmit: begin
				// port a shows the term, nothing moves until it is taken
				regs.readRegA = cnt.emitPtr;
				if (termTaken) begin
					if (termLast) begin
						nextState = stIdle;
					end else if (firstTerm) begin
						// second term is seed1, already in place
						nextState = stEmit;
					end else begin
						nextState = stStep;
					end
				end
			end

			stStep: begin
				// r[wrPtr] = r[wrPtr-1] + r[wrPtr-2]
				writeEn = 1'b1;
				regs.readRegA = cnt.prevPtrA;
				regs.readRegB = cnt.prevPtrB;
				regs.op = opAdd;
				nextState = stEmit;
			end

			default: begin
				nextState = stIdle;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// state and flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			ovfPending <= 1'b0;
			firstTerm <= 1'b0;
		end else begin
			state <= nextState;
			if (accept) begin
				ovfPending <= 1'b0;
				firstTerm <= 1'b1;
			end else begin
				if (state == stStep) begin
					ovfPending <= regs.carry;
				end
				if (termTaken) begin
					firstTerm <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			seed1Hold <= reqSeed1;
		end
	end

endmodule

//--- logic/stepCounter.sv
`timescale 1ns/100ps

module stepCounter import fibPkg::*; (
	input logic clk,
	input logic rstN,
	termCountIf.cnt cnt
);

	regAddr_t wrPtrQ;
	regAddr_t emitPtrQ;

	// terms still to be sent for this request
	count_t remaining;

	//////////////////////////////////////////////////
	// counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtrQ <= '0;
			emitPtrQ <= '0;
			remaining <= '0;
		end else if (cnt.load) begin
			// both pointers restart at r0, seed0 goes there in the same cycle
			remaining <= cnt.count;
			emitPtrQ <= '0;
			if (cnt.writeStep) begin
				wrPtrQ <= regAddr_t'(1);
			end else begin
				wrPtrQ <= '0;
			end
		end else begin
			if (cnt.writeStep) begin
				wrPtrQ <= wrPtrQ + 1'b1;
			end
			if (cnt.emitStep) begin
				emitPtrQ <= emitPtrQ + 1'b1;
				remaining <= remaining - 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// derived pointers
	//////////////////////////////////////////////////

	assign cnt.wrPtr = wrPtrQ;
	assign cnt.emitPtr = emitPtrQ;

	// wrap around the register file for free at regAddrWidth bits
	assign cnt.prevPtrA = wrPtrQ - regAddr_t'(1);
	assign cnt.prevPtrB = wrPtrQ - regAddr_t'(2);

	assign cnt.lastTerm = (remaining == count_t'(1));

endmodule

//--- logic/termCountIf.sv
`timescale 1ns/100ps

interface termCountIf import fibPkg::*; ();

	// from the controller
	logic load;
	count_t count;
	logic writeStep;
	logic emitStep;

	// register pointers, all modulo numRegs
	regAddr_t wrPtr;
	regAddr_t prevPtrA;
	regAddr_t prevPtrB;
	regAddr_t emitPtr;

	// one term left to send
	logic lastTerm;

	modport ctrl (
		output load, count, writeStep, emitStep,
		input wrPtr, prevPtrA, prevPtrB, emitPtr, lastTerm
	);

	modport cnt (
		input load, count, writeStep, emitStep,
		output wrPtr, prevPtrA, prevPtrB, emitPtr, lastTerm
	);

endinterface

//--- test/fibSequencerTb.sv
`timescale 1ns/100ps

module fibSequencerTb import fibPkg::*; ();

	localparam int waitLimit = 2000;
	localparam int numSmall = 12;
	localparam int numLarge = 6;
	localparam int numWrap = 40;
	localparam int totalRequests = numSmall + numLarge + 2 + numWrap;

	logic clk;
	logic rstN;
	logic reqValid;
	logic reqReady;
	data_t reqSeed0;
	data_t reqSeed1;
	count_t reqCount;
	logic termValid;
	logic termReady;
	data_t termData;
	logic termLast;
	logic termOverflow;

	// expected terms in the order the requests were accepted
	data_t expData[$];
	logic expLast[$];
	logic expOvf[$];
	// terms each accepted request should produce
	count_t expCount[$];

	fibSequencer dut (.*);

	always #10 clk = ~clk;

	// random back-pressure on the term stream
	always @(posedge clk) begin
		#2;
		termReady = ($urandom_range(0, 2) != 0);
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkTerm(input data_t got, input data_t exp);
		if (got !== exp) begin
			stopOnError($sformatf("FAILED termData: got %h, expected %h", got, exp));
		end
	endtask

	task automatic checkFlags(input logic gotLast, input logic gotOvf,
			input logic expLastBit, input logic expOvfBit);
		if (gotLast !== expLastBit) begin
			stopOnError($sformatf("FAILED termLast: got %h, expected %h", gotLast, expLastBit));
		end
		if (gotOvf !== expOvfBit) begin
			stopOnError($sformatf("FAILED termOverflow: got %h, expected %h", gotOvf, expOvfBit));
		end
	endtask

	task automatic checkCount(input int idx, input count_t got, input count_t exp);
		if (got !== exp) begin
			stopOnError($sformatf("FAILED term count of request %0d: got %h, expected %h",
				idx, got, exp));
		end
	endtask

	task automatic checkHandshake(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stopOnError($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	//////////////////////////////////////////////////
	// sequence model
	//////////////////////////////////////////////////

	// seeds first, then the sum of the two previous terms until n or a carry
	function automatic count_t predictTerms(input data_t s0, input data_t s1, input count_t n);
		int unsigned prev2;
		int unsigned prev1;
		int unsigned next;
		logic ovf;
		count_t produced;
		prev2 = 0;
		prev1 = 0;
		produced = '0;
		for (int k = 0; k < n; k++) begin
			if (k == 0) begin
				next = s0;
			end else if (k == 1) begin
				next = s1;
			end else begin
				next = prev1 + prev2;
			end
			ovf = (next >= 65536);
			expData.push_back(data_t'(next));
			expLast.push_back((k == n - 1) || ovf);
			expOvf.push_back(ovf);
			produced++;
			if (ovf) begin
				break;
			end
			prev2 = prev1;
			prev1 = next;
		end
		return produced;
	endfunction

	//////////////////////////////////////////////////
	// request side
	//////////////////////////////////////////////////

	task automatic sendRequest(input data_t s0, input data_t s1, input count_t n);
		int cycles;
		logic accepted;
		reqValid = 1'b1;
		reqSeed0 = s0;
		reqSeed1 = s1;
		reqCount = n;
		cycles = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			cycles++;
			if (reqReady) begin
				accepted = 1'b1;
				expCount.push_back(predictTerms(s0, s1, n));
			end else if (cycles > waitLimit) begin
				stopOnError("request was not accepted before the timeout");
			end
		end
		@(posedge clk);
		#2;
		reqValid = 1'b0;
	endtask

	task automatic driveRequests();
		repeat (numSmall) begin
			sendRequest(data_t'($urandom_range(0, 255)), data_t'($urandom_range(0, 255)),
				count_t'($urandom_range(1, 20)));
		end
		// large seeds carry out within a few adds
		repeat (numLarge) begin
			sendRequest(data_t'($urandom_range(16384, 65535)),
				data_t'($urandom_range(16384, 65535)), count_t'($urandom_range(6, 20)));
		end
		sendRequest(data_t'($urandom_range(0, 255)), data_t'($urandom_range(0, 255)), '0);
		sendRequest(data_t'($urandom_range(0, 255)), data_t'($urandom_range(0, 255)), 8'd5);
		// long sequences wrap both register pointers
		repeat (numWrap) begin
			sendRequest(data_t'($urandom_range(0, 3)), data_t'($urandom_range(0, 3)),
				count_t'($urandom_range(17, 24)));
		end
	endtask

	//////////////////////////////////////////////////
	// term side
	//////////////////////////////////////////////////

	// a held term must keep its data and flags until it is taken
	task automatic waitTerm(output data_t data, output logic last, output logic ovf);
		int cycles;
		logic taken;
		logic held;
		data_t heldData;
		logic heldLast;
		logic heldOvf;
		cycles = 0;
		taken = 1'b0;
		held = 1'b0;
		while (!taken) begin
			@(negedge clk);
			cycles++;
			if (held) begin
				checkHandshake("termValid", termValid, 1'b1);
				checkTerm(termData, heldData);
				checkFlags(termLast, termOverflow, heldLast, heldOvf);
			end
			if (termValid && termReady) begin
				taken = 1'b1;
				data = termData;
				last = termLast;
				ovf = termOverflow;
			end else if (cycles > waitLimit) begin
				stopOnError("no term was transferred before the timeout");
			end
			held = termValid && !termReady;
			heldData = termData;
			heldLast = termLast;
			heldOvf = termOverflow;
		end
	endtask

	task automatic receiveRequest(input int idx);
		int cycles;
		count_t n;
		count_t got;
		logic done;
		data_t data;
		logic last;
		logic ovf;
		cycles = 0;
		while (expCount.size() == 0) begin
			@(negedge clk);
			cycles++;
			if (termValid) begin
				stopOnError("a term appeared while no request was outstanding");
			end
			if (cycles > waitLimit) begin
				stopOnError("no request was accepted before the timeout");
			end
		end
		n = expCount.pop_front();
		got = '0;
		done = (n == '0);
		while (!done) begin
			waitTerm(data, last, ovf);
			checkTerm(data, expData.pop_front());
			checkFlags(last, ovf, expLast.pop_front(), expOvf.pop_front());
			got++;
			done = last;
		end
		checkCount(idx, got, n);
		// back to idle right after the final term
		if (n != '0) begin
			@(negedge clk);
			checkHandshake("reqReady", reqReady, 1'b1);
		end
	endtask

	//////////////////////////////////////////////////
	// main
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(39));
		clk = 1'b0;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqSeed0 = '0;
		reqSeed1 = '0;
		reqCount = '0;
		termReady = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(negedge clk);
		checkHandshake("reqReady", reqReady, 1'b1);
		checkHandshake("termValid", termValid, 1'b0);
		@(posedge clk);
		#2;
		fork
			driveRequests();
			for (int i = 0; i < totalRequests; i++) begin
				receiveRequest(i);
			end
		join
		$display("TEST OK");
		$finish;
	end

endmodule

//--- verilog.f
logic/fibPkg.sv
logic/regCtrlIf.sv
logic/termCountIf.sv
logic/seqController.sv
logic/stepCounter.sv
logic/fibDatapath.sv
logic/fibSequencer.sv
test/fibSequencerTb.sv
